// ==== cam_bist_pkg.sv ====
/*
 * CAM self-test shared definitions
 * Array geometry, phase encoding, pipeline op struct and register map
 */
package cam_bist_pkg;

  // ==========================================================================
  // Array geometry
  // ==========================================================================
  localparam int cam_entries = 32;
  localparam int cam_dwidth  = 16;
  localparam int cam_awidth  = 5;

  typedef logic [cam_awidth-1:0]  cam_addr_t;
  typedef logic [cam_dwidth-1:0]  cam_data_t;
  typedef logic [cam_entries-1:0] cam_match_t;

  // Expected match-line selection
  typedef logic [1:0] match_sel_t;
  localparam match_sel_t sel_all_match   = 2'd0;
  localparam match_sel_t sel_single_match = 2'd1;
  localparam match_sel_t sel_single_miss = 2'd2;
  localparam match_sel_t sel_all_miss    = 2'd3;

  // Algorithm phases, in run order
  typedef enum logic [2:0] {
    IDLE             = 3'd0,
    WR_UNIQUE        = 3'd1,
    RD_UNIQUE        = 3'd2,
    SRCH_SINGLE      = 3'd3,
    SRCH_NONE        = 3'd4,
    WR_ONES          = 3'd5,
    SRCH_ALL         = 3'd6,
    SRCH_SINGLE_MISS = 3'd7
  } bist_phase_t;

  // One compared operation; valid only for reads and searches
  typedef struct packed {
    logic        valid;
    logic        cm_mode;
    match_sel_t  sel;
    cam_addr_t   addr;
    bist_phase_t phase;
    cam_data_t   exp_data;
  } bist_op_t;

  typedef struct packed {
    logic             en;
    cam_addr_t        entry;
    logic [3:0]       bit_idx;
  } fault_cfg_t;

  typedef struct packed {
    logic        busy;
    logic        done;
    logic        fail;
    bist_phase_t fail_phase;
    cam_addr_t   fail_addr;
  } bist_status_t;

  // ==========================================================================
  // AXI4-Lite register port
  // ==========================================================================
  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_resp_t axi_okay = 2'b00;

  localparam axi_addr_t reg_ctrl   = 32'h0;
  localparam axi_addr_t reg_fault  = 32'h4;
  localparam axi_addr_t reg_status = 32'h8;

endpackage

// ==== cam_array.sv ====
/*
 * Behavioral 32x16 CAM array
 * Register storage with write, read and search. Results leave through two
 * register stages. One bit can be forced to read and compare as 0.
 */
`timescale 1ns/1ps

module cam_array (
  input  logic                     bist_clk,
  input  logic                     arst_n,
  input  logic                     we,
  input  cam_bist_pkg::cam_addr_t  wr_addr,
  input  cam_bist_pkg::cam_data_t  wr_data,
  input  logic                     re,
  input  cam_bist_pkg::cam_addr_t  rd_addr,
  input  logic                     se,
  input  cam_bist_pkg::cam_data_t  key,
  input  cam_bist_pkg::fault_cfg_t fault,
  output cam_bist_pkg::cam_data_t  rd_data,
  output cam_bist_pkg::cam_match_t match
);
  import cam_bist_pkg::*;

  cam_data_t  mem [cam_entries];
  cam_data_t  eff [cam_entries];
  cam_match_t match_raw;
  cam_data_t  rd_s1;
  cam_match_t match_s1;

  // Storage
  always_ff @(posedge bist_clk) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Effective contents as seen by read and compare
  // Stuck-at-0 applied to a single cell when enabled
  always_comb begin
    for (int e = 0; e < cam_entries; e++) begin
      eff[e] = mem[e];
      if (fault.en && fault.entry == cam_addr_t'(e)) begin
        eff[e][fault.bit_idx] = 1'b0;
      end
    end
  end

  // Parallel compare of the key against every entry
  always_comb begin
    for (int e = 0; e < cam_entries; e++) begin
      match_raw[e] = se && (eff[e] == key);
    end
  end

  // ==========================================================================
  // Two-stage output pipeline
  // ==========================================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_s1    <= '0;
      match_s1 <= '0;
      rd_data  <= '0;
      match    <= '0;
    end else begin
      // Read data holds when no read is issued
      if (re) begin
        rd_s1 <= eff[rd_addr];
      end
      match_s1 <= match_raw;
      rd_data  <= rd_s1;
      match    <= match_s1;
    end
  end

endmodule

// ==== cam_bist_ctrl.sv ====
/*
 * CAM BIST sequencer
 * Steps through the algorithm phases and issues one array operation per
 * cycle, with the matching compare op for the output path
 */
`timescale 1ns/1ps

module cam_bist_ctrl (
  input  logic                     bist_clk,
  input  logic                     arst_n,
  input  logic                     start,
  output logic                     we,
  output cam_bist_pkg::cam_addr_t  wr_addr,
  output cam_bist_pkg::cam_data_t  wr_data,
  output logic                     re,
  output cam_bist_pkg::cam_addr_t  rd_addr,
  output logic                     se,
  output cam_bist_pkg::cam_data_t  key,
  output cam_bist_pkg::bist_op_t   op,
  output logic                     busy,
  output logic                     done
);
  import cam_bist_pkg::*;

  localparam cam_addr_t last_addr = cam_addr_t'(cam_entries - 1);

  bist_phase_t phase;
  cam_addr_t   addr;
  logic [1:0]  sub;
  logic [1:0]  drain_cnt;
  cam_data_t   pat;

  // Unique pattern, upper byte is the complement of the entry number
  assign pat = {~{3'b000, addr}, {3'b000, addr}};

  // ==========================================================================
  // Phase, address and sub-step sequencing
  // ==========================================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase     <= IDLE;
      addr      <= '0;
      sub       <= '0;
      drain_cnt <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else begin
      case (phase)
        IDLE: begin
          if (start && !busy) begin
            phase     <= WR_UNIQUE;
            addr      <= '0;
            sub       <= '0;
            drain_cnt <= '0;
            busy      <= 1'b1;
            done      <= 1'b0;
          end else if (busy) begin
            // Drain until the last result has been checked
            if (drain_cnt == 2'd2) begin
              busy <= 1'b0;
              done <= 1'b1;
            end else begin
              drain_cnt <= drain_cnt + 2'd1;
            end
          end
        end
        SRCH_SINGLE_MISS: begin
          // Write 0, search ones, restore ones
          if (sub == 2'd2) begin
            sub  <= '0;
            addr <= addr + cam_addr_t'(1);
            if (addr == last_addr) begin
              phase <= IDLE;
            end
          end else begin
            sub <= sub + 2'd1;
          end
        end
        default: begin
          addr <= addr + cam_addr_t'(1);
          if (addr == last_addr) begin
            phase <= bist_phase_t'(phase + 3'd1);
          end
        end
      endcase
    end
  end

  // ==========================================================================
  // Array request and compare op for the current step
  // ==========================================================================
  always_comb begin
    we      = 1'b0;
    wr_addr = addr;
    wr_data = '0;
    re      = 1'b0;
    rd_addr = addr;
    se      = 1'b0;
    key     = '0;
    op      = '0;
    op.addr  = addr;
    op.phase = phase;
    case (phase)
      WR_UNIQUE: begin
        we      = 1'b1;
        wr_data = pat;
      end
      RD_UNIQUE: begin
        re          = 1'b1;
        op.valid    = 1'b1;
        op.exp_data = pat;
      end
      SRCH_SINGLE: begin
        se         = 1'b1;
        key        = pat;
        op.valid   = 1'b1;
        op.cm_mode = 1'b1;
        op.sel     = sel_single_match;
      end
      SRCH_NONE: begin
        // No entry ever holds all zeros
        se         = 1'b1;
        op.valid   = 1'b1;
        op.cm_mode = 1'b1;
        op.sel     = sel_all_miss;
      end
      WR_ONES: begin
        we      = 1'b1;
        wr_data = '1;
      end
      SRCH_ALL: begin
        se         = 1'b1;
        key        = '1;
        op.valid   = 1'b1;
        op.cm_mode = 1'b1;
        op.sel     = sel_all_match;
      end
      SRCH_SINGLE_MISS: begin
        if (sub == 2'd1) begin
          se         = 1'b1;
          key        = '1;
          op.valid   = 1'b1;
          op.cm_mode = 1'b1;
          op.sel     = sel_single_miss;
        end else begin
          we      = 1'b1;
          wr_data = (sub == 2'd0) ? '0 : '1;
        end
      end
      default: begin
        // Idle or draining, nothing issued
      end
    endcase
  end

endmodule

// ==== cam_bist_outhandler.sv ====
/*
 * CAM BIST output handler
 * Builds expected match lines, compares and folds them to the data width,
 * and selects the folded result or the read data
 */
`timescale 1ns/1ps

module cam_bist_outhandler (
  input  logic                     bist_clk,
  input  logic                     arst_n,
  input  cam_bist_pkg::bist_op_t   op_in,
  input  cam_bist_pkg::cam_match_t match,
  input  cam_bist_pkg::cam_data_t  rd_data,
  output cam_bist_pkg::bist_op_t   op_out,
  output cam_bist_pkg::cam_data_t  data_out
);
  import cam_bist_pkg::*;

  bist_op_t   op_d1;
  bist_op_t   op_d2;
  cam_match_t exp_match;
  cam_match_t diff;
  cam_data_t  folded;

  // Align the op with the array latency
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      op_d1 <= '0;
      op_d2 <= '0;
    end else begin
      op_d1 <= op_in;
      op_d2 <= op_d1;
    end
  end

  // ==========================================================================
  // Expected match vector
  // ==========================================================================
  always_comb begin
    case (op_d2.sel)
      sel_all_match:    exp_match = '1;
      sel_single_match: exp_match = cam_match_t'(1) << op_d2.addr;
      sel_single_miss:  exp_match = ~(cam_match_t'(1) << op_d2.addr);
      default:          exp_match = '0;
    endcase
  end

  // Any set bit marks a wrong match line
  assign diff = exp_match ^ match;

  // Fold lines i and i+16 onto bit i
  always_comb begin
    for (int i = 0; i < cam_dwidth; i++) begin
      folded[i] = diff[i] | diff[i + cam_dwidth];
    end
  end

  assign data_out = op_d2.cm_mode ? folded : rd_data;
  assign op_out   = op_d2;

endmodule

// ==== cam_bist_checker.sv ====
/*
 * CAM BIST checker
 * Compares the output path with the expected word and keeps the first fail
 */
`timescale 1ns/1ps

module cam_bist_checker (
  input  logic                      bist_clk,
  input  logic                      arst_n,
  input  logic                      clear,
  input  cam_bist_pkg::bist_op_t    op,
  input  cam_bist_pkg::cam_data_t   data_out,
  output logic                      fail,
  output cam_bist_pkg::bist_phase_t fail_phase,
  output cam_bist_pkg::cam_addr_t   fail_addr
);
  import cam_bist_pkg::*;

  logic miscompare;

  // Searches expect zero, reads expect the stored pattern
  assign miscompare = op.valid && (data_out != op.exp_data);

  // Sticky record, only the first miscompare after clear is kept
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      fail       <= 1'b0;
      fail_phase <= IDLE;
      fail_addr  <= '0;
    end else if (clear) begin
      fail       <= 1'b0;
      fail_phase <= IDLE;
      fail_addr  <= '0;
    end else if (miscompare && !fail) begin
      fail       <= 1'b1;
      fail_phase <= op.phase;
      fail_addr  <= op.addr;
    end
  end

endmodule

// ==== cam_bist_regs.sv ====
/*
 * CAM BIST register block
 * AXI4-Lite slave with start control, fault injection point and run status
 */
`timescale 1ns/1ps

module cam_bist_regs (
  input  logic                       bist_clk,
  input  logic                       arst_n,
  input  cam_bist_pkg::axi_addr_t    awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  cam_bist_pkg::axi_data_t    wdata,
  input  cam_bist_pkg::axi_strb_t    wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output cam_bist_pkg::axi_resp_t    bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  cam_bist_pkg::axi_addr_t    araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output cam_bist_pkg::axi_data_t    rdata,
  output cam_bist_pkg::axi_resp_t    rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output logic                       start,
  output cam_bist_pkg::fault_cfg_t   fault,
  input  cam_bist_pkg::bist_status_t status
);
  import cam_bist_pkg::*;

  logic      wr_fire;
  logic      rd_fire;
  axi_data_t wmask;
  axi_data_t fault_word;
  axi_data_t fault_new;
  axi_data_t status_word;
  axi_data_t rd_word;

  // ==========================================================================
  // Handshakes
  // ==========================================================================
  // AW and W taken together, one write in flight
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign wr_fire = awvalid && awready;
  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;
  assign bresp   = axi_okay;
  assign rresp   = axi_okay;

  // Byte-lane merge for the fault register
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      wmask[8*b +: 8] = {8{wstrb[b]}};
    end
  end

  assign fault_word  = {16'h0, fault.bit_idx, 3'b000, fault.entry, 3'b000, fault.en};
  assign fault_new   = (fault_word & ~wmask) | (wdata & wmask);
  assign status_word = {19'h0, status.fail_addr, 1'b0, status.fail_phase,
                        1'b0, status.fail, status.done, status.busy};

  // Read mux, control reads back zero
  always_comb begin
    case (araddr)
      reg_fault:  rd_word = fault_word;
      reg_status: rd_word = status_word;
      default:    rd_word = '0;
    endcase
  end

  // ==========================================================================
  // Register state
  // ==========================================================================
  always_ff @(posedge bist_clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      start  <= 1'b0;
      fault  <= '0;
    end else begin
      start <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (awaddr)
          // Start is dropped while a run is in progress
          reg_ctrl:  start <= wstrb[0] && wdata[0] && !status.busy;
          reg_fault: fault <= '{en:      fault_new[0],
                                entry:   fault_new[8:4],
                                bit_idx: fault_new[15:12]};
          default: begin
            // Status and unmapped writes have no effect
          end
        endcase
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Read data captured with the AR handshake
  always_ff @(posedge bist_clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
    end
  end

endmodule

// ==== cam_bist_top.sv ====
/*
 * CAM self-test subsystem top
 * Registers, sequencer, array, output handler and checker
 */
`timescale 1ns/1ps

module cam_bist_top (
  input  logic                    bist_clk,
  input  logic                    arst_n,
  input  cam_bist_pkg::axi_addr_t awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  cam_bist_pkg::axi_data_t wdata,
  input  cam_bist_pkg::axi_strb_t wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output cam_bist_pkg::axi_resp_t bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  cam_bist_pkg::axi_addr_t araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output cam_bist_pkg::axi_data_t rdata,
  output cam_bist_pkg::axi_resp_t rresp,
  output logic                    rvalid,
  input  logic                    rready
);
  import cam_bist_pkg::*;

  logic         start;
  fault_cfg_t   fault;
  bist_status_t status;
  logic         we;
  cam_addr_t    wr_addr;
  cam_data_t    wr_data;
  logic         re;
  cam_addr_t    rd_addr;
  logic         se;
  cam_data_t    key;
  cam_data_t    rd_data;
  cam_match_t   match;
  bist_op_t     op;
  bist_op_t     op_chk;
  cam_data_t    data_out;
  logic         busy;
  logic         done;
  logic         fail;
  bist_phase_t  fail_phase;
  cam_addr_t    fail_addr;

  assign status = '{busy: busy, done: done, fail: fail,
                    fail_phase: fail_phase, fail_addr: fail_addr};

  cam_bist_regs u_regs (
    .bist_clk, .arst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .start, .fault, .status
  );

  cam_bist_ctrl u_ctrl (
    .bist_clk, .arst_n, .start,
    .we, .wr_addr, .wr_data, .re, .rd_addr, .se, .key,
    .op, .busy, .done
  );

  cam_array u_array (
    .bist_clk, .arst_n,
    .we, .wr_addr, .wr_data, .re, .rd_addr, .se, .key,
    .fault, .rd_data, .match
  );

  cam_bist_outhandler u_outhandler (
    .bist_clk, .arst_n,
    .op_in    (op),
    .match, .rd_data,
    .op_out   (op_chk),
    .data_out
  );

  // Accepted start clears the previous fail record
  cam_bist_checker u_checker (
    .bist_clk, .arst_n,
    .clear    (start),
    .op       (op_chk),
    .data_out, .fail, .fail_phase, .fail_addr
  );

endmodule

// ==== tb_cam_bist.sv ====
/*
 * Directed testbench for the CAM self-test subsystem
 * Drives the AXI4-Lite port, injects stuck-at-0 faults and checks run status
 */
`timescale 1ns/1ps

module tb_cam_bist;
  import cam_bist_pkg::*;

  // ==========================================================================
  // Clock, reset and run limit
  // ==========================================================================
  localparam int half_period  = 4;
  localparam int reset_cycles = 16;
  // Nine runs of about 300 cycles each, plus register traffic and reset
  localparam int max_cycles   = 3000;

  logic      bist_clk;
  logic      arst_n;
  axi_addr_t awaddr;
  logic      awvalid;
  logic      awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wvalid;
  logic      wready;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;
  axi_addr_t araddr;
  logic      arvalid;
  logic      arready;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic      rvalid;
  logic      rready;

  int error_count  = 0;
  int test_count   = 0;
  int failed_tests = 0;
  int cycle_count  = 0;
  int seed;

  cam_bist_top dut_i (
    .bist_clk, .arst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  initial begin
    bist_clk = 1'b0;
    forever #(half_period) bist_clk = ~bist_clk;
  end

  // Watchdog over the whole run
  initial begin : watchdog
    while (cycle_count < max_cycles) begin
      @(posedge bist_clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", max_cycles);
    $display("TEST FAILED");
    $finish;
  end

  // ==========================================================================
  // Checking and expected values
  // ==========================================================================
  task automatic check_equal(input string what, input axi_data_t got, input axi_data_t exp);
    assert (got === exp) else begin
      $display("** Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    test_count++;
    if (error_count == start_errors) begin
      $display("Test %0d, %s: ok", test_count, name);
    end else begin
      failed_tests++;
      $display("Test %0d, %s: %0d errors", test_count, name, error_count - start_errors);
    end
  endtask

  // Status layout from the register map
  function automatic axi_data_t status_value(input logic busy, input logic done,
      input logic fail, input logic [2:0] phase, input cam_addr_t addr);
    return {19'h0, addr, 1'b0, phase, 1'b0, fail, done, busy};
  endfunction

  function automatic axi_data_t fault_value(input logic en, input cam_addr_t entry,
      input logic [3:0] bit_idx);
    return {16'h0, bit_idx, 3'b000, entry, 3'b000, en};
  endfunction

  // Where the first miscompare of a run shows for a stuck-at-0 cell
  function automatic void predict_fail(input cam_addr_t entry, input logic [3:0] bit_idx,
      output bist_phase_t phase, output cam_addr_t addr);
    logic [7:0]  num;
    logic [15:0] pattern;
    num     = {3'b000, entry};
    pattern = {~num, num};
    if (pattern[bit_idx]) begin
      // A lost one is caught by the read-back of that entry
      phase = RD_UNIQUE;
      addr  = entry;
    end else begin
      // Hidden until all entries hold ones, the first all-match search sees it
      phase = SRCH_ALL;
      addr  = '0;
    end
  endfunction

  // ==========================================================================
  // AXI4-Lite master
  // ==========================================================================
  task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
    @(posedge bist_clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(negedge bist_clk); while (!(awready && wready));
    @(posedge bist_clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    do @(negedge bist_clk); while (!bvalid);
    check_equal("write response", 32'(bresp), 32'(axi_okay));
    @(posedge bist_clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
    @(posedge bist_clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    do @(negedge bist_clk); while (!arready);
    @(posedge bist_clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    do @(negedge bist_clk); while (!rvalid);
    data = rdata;
    check_equal("read response", 32'(rresp), 32'(axi_okay));
    @(posedge bist_clk);
    #1;
    rready = 1'b0;
  endtask

  // Start a run and poll status until done
  // The first poll lands well inside the run, so busy is set and the old record cleared
  task automatic run_bist(output axi_data_t st);
    axi_write(reg_ctrl, 32'h1);
    axi_read(reg_status, st);
    check_equal("status just after start", 32'(st[2:0]), 32'h1);
    while (!st[1]) begin
      axi_read(reg_status, st);
    end
  endtask

  task automatic run_with_fault(input cam_addr_t entry, input logic [3:0] bit_idx,
      input bist_phase_t exp_phase, input cam_addr_t exp_addr);
    axi_data_t st;
    axi_write(reg_fault, fault_value(1'b1, entry, bit_idx));
    run_bist(st);
    check_equal($sformatf("status for fault at entry %0d bit %0d", entry, bit_idx), st,
                status_value(1'b0, 1'b1, 1'b1, exp_phase, exp_addr));
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================
  task automatic read_reset_values();
    int        start_errors;
    axi_data_t rd;
    start_errors = error_count;
    axi_read(reg_status, rd);
    check_equal("status after reset", rd, '0);
    axi_read(reg_ctrl, rd);
    check_equal("ctrl after reset", rd, '0);
    axi_read(reg_fault, rd);
    check_equal("fault after reset", rd, '0);
    // Status is read-only
    axi_write(reg_status, 32'hffff_ffff);
    axi_read(reg_status, rd);
    check_equal("status after write", rd, '0);
    finish_test("reset values", start_errors);
  endtask

  task automatic run_fault_free();
    int        start_errors;
    axi_data_t st;
    start_errors = error_count;
    run_bist(st);
    check_equal("status after clean run", st, status_value(1'b0, 1'b1, 1'b0, IDLE, '0));
    finish_test("fault-free run", start_errors);
  endtask

  task automatic catch_pattern_one_faults();
    int start_errors;
    start_errors = error_count;
    // Bits that are one in the unique pattern of each entry
    run_with_fault(5'd0, 4'd8, RD_UNIQUE, 5'd0);
    run_with_fault(5'd9, 4'd0, RD_UNIQUE, 5'd9);
    run_with_fault(5'd31, 4'd4, RD_UNIQUE, 5'd31);
    finish_test("faults on pattern ones", start_errors);
  endtask

  task automatic catch_pattern_zero_fault();
    int start_errors;
    start_errors = error_count;
    // Entry 20 holds 0xeb14, bit 5 is zero
    run_with_fault(5'd20, 4'd5, SRCH_ALL, 5'd0);
    finish_test("fault on pattern zero", start_errors);
  endtask

  task automatic clear_fault_and_rerun();
    int        start_errors;
    axi_data_t rd;
    axi_data_t st;
    start_errors = error_count;
    axi_write(reg_fault, 32'hffff_ffff);
    axi_read(reg_fault, rd);
    check_equal("fault fields", rd, 32'h0000_f1f1);
    axi_write(reg_fault, fault_value(1'b1, 5'd13, 4'd10));
    axi_read(reg_fault, rd);
    check_equal("fault readback", rd, fault_value(1'b1, 5'd13, 4'd10));
    // Record of the previous failing run still held
    axi_read(reg_status, rd);
    check_equal("old fail bit", 32'(rd[2]), 32'h1);
    axi_write(reg_fault, '0);
    run_bist(st);
    check_equal("status after fault cleared", st, status_value(1'b0, 1'b1, 1'b0, IDLE, '0));
    finish_test("fault readback and clear", start_errors);
  endtask

  task automatic sweep_random_faults();
    int          start_errors;
    axi_data_t   rnd;
    cam_addr_t   entry;
    logic [3:0]  bit_idx;
    bist_phase_t exp_phase;
    cam_addr_t   exp_addr;
    start_errors = error_count;
    for (int n = 0; n < 3; n++) begin
      rnd     = $random(seed);
      entry   = rnd[4:0];
      bit_idx = rnd[11:8];
      predict_fail(entry, bit_idx, exp_phase, exp_addr);
      run_with_fault(entry, bit_idx, exp_phase, exp_addr);
    end
    finish_test("random faults", start_errors);
  endtask

  initial begin : main
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    seed    = 81;
    repeat (reset_cycles) @(posedge bist_clk);
    #1;
    arst_n = 1'b1;

    read_reset_values();
    run_fault_free();
    catch_pattern_one_faults();
    catch_pattern_zero_fault();
    clear_fault_and_rerun();
    sweep_random_faults();

    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
cam_bist_pkg.sv
cam_array.sv
cam_bist_ctrl.sv
cam_bist_outhandler.sv
cam_bist_checker.sv
cam_bist_regs.sv
cam_bist_top.sv
tb_cam_bist.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cam_bist
FILELIST = files.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
